// ==== run_sim.sh ====
#!/bin/sh
# Build and run the MXINT accumulation testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_mxint_accum_top -f vlog.f -o sim_tb > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 ; cat sim.log

grep -q "Simulation finished: FAIL" sim.log && { echo "Test failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "No result in log"; exit 1; }
exit 0

// ==== verif/tb_mxint_accum_top.sv ====
module tb_mxint_accum_top;

  import mxint_format_pkg::*;
  import mxint_flow_pkg::*;

  localparam int BLOCK_SIZE = BLOCK_SIZE_DEF;
  localparam int FIFO_DEPTH = FIFO_DEPTH_DEF;
  localparam int IN_DEPTH   = IN_DEPTH_DEF;
  localparam int ACC_W      = acc_width(MANT_W, EXP_W, IN_DEPTH);
  localparam int WAIT_LIMIT = 400;

  logic                    clk;
  logic                    rst;
  logic signed [RAW_W-1:0] in_data [BLOCK_SIZE];
  logic                    in_valid;
  logic                    in_ready;
  logic signed [ACC_W-1:0] out_mant [BLOCK_SIZE];
  logic signed [EXP_W-1:0] out_exp;
  logic                    out_valid;
  logic                    out_ready;

  logic [15:0] lfsr;

  // Expected results hold one exponent and BLOCK_SIZE lanes per entry.
  int     exp_q [$];
  longint mant_q [$];
  logic   head_valid;
  int     head_exp;
  longint head_mant [BLOCK_SIZE];

  logic                        mant_match;
  logic                        mant_zero;
  logic [BLOCK_SIZE*ACC_W-1:0] out_flat;

  int     blocks_in;
  int     results_seen;
  int     results_expected;
  int     grp_n;
  int     acc_exp;
  longint acc [BLOCK_SIZE];

  mxint_accum_top #(
    .BLOCK_SIZE (BLOCK_SIZE),
    .RAW_W      (RAW_W),
    .MANT_W     (MANT_W),
    .EXP_W      (EXP_W),
    .FIFO_DEPTH (FIFO_DEPTH),
    .IN_DEPTH   (IN_DEPTH)
  ) uut (
    .clk       (clk),
    .rst       (rst),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_mant  (out_mant),
    .out_exp   (out_exp),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at first error.");
  endtask

  // Galois LFSR stepped once per bit handed out.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus.
  //////////////////////////////////////////////////////////////////////

  // Mode 0 gives small lanes, 1 wide lanes and 2 either per block.
  task automatic present_block(input int mode);
    logic signed [RAW_W-1:0] v;
    bit                      wide;
    wide = (mode == 1) || (mode == 2 && take_bits(1) != 0);
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      if (wide) begin
        v = $signed(RAW_W'(take_bits(RAW_W)));
        v = v >>> take_bits(3);
      end else begin
        v = $signed(MANT_W'(take_bits(MANT_W)));
      end
      in_data[i] <= v;
    end
    in_valid <= 1'b1;
  endtask

  task automatic drive_blocks(input int count, input int mode, input bit gaps, input bit stall);
    int issued;
    int sent;
    int n;
    // A block still waiting at the input counts as issued.
    issued = (in_valid && !in_ready) ? 1 : 0;
    sent   = 0;
    n      = 0;
    while (sent < count) begin
      @(posedge clk);
      n++;
      if (n > 20 * count + WAIT_LIMIT)
        abort_run("Timeout: input blocks were not accepted in time.");
      if (in_valid && in_ready)
        sent++;
      if (!in_valid || in_ready) begin
        if (issued < count && (!gaps || take_bits(1) != 0)) begin
          present_block(mode);
          issued++;
        end else begin
          in_valid <= 1'b0;
        end
      end
      out_ready <= stall ? (take_bits(1) != 0) : 1'b1;
    end
  endtask

  // Leaves one block pending at the input once in_ready drops.
  task automatic fill_until_blocked(output int accepted);
    int n;
    bit blocked;
    accepted  = 0;
    n         = 0;
    blocked   = 1'b0;
    out_ready <= 1'b0;
    while (!blocked) begin
      @(posedge clk);
      n++;
      if (n > WAIT_LIMIT)
        abort_run("Timeout: in_ready never fell while out_ready was held low.");
      if (in_valid && !in_ready) begin
        blocked = 1'b1;
      end else begin
        if (in_valid)
          accepted++;
        present_block(1);
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT)
        abort_run("Timeout: expected results did not drain from the DUT.");
    end while (exp_q.size() != 0 || out_valid);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model and scoreboard.
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    int     e;
    int     t;
    bit     found;
    bit     fits;
    longint v;
    longint m [BLOCK_SIZE];
    if (rst) begin
      exp_q.delete();
      mant_q.delete();
      blocks_in        = 0;
      results_seen     = 0;
      results_expected = 0;
      grp_n            = 0;
    end else begin
      if (out_valid && out_ready && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        repeat (BLOCK_SIZE) void'(mant_q.pop_front());
        results_seen++;
      end
      if (in_valid && in_ready) begin
        // Smallest shift that puts every lane in mantissa range.
        found = 1'b0;
        e     = 0;
        for (int s = 0; s < RAW_W; s++) begin
          fits = 1'b1;
          for (int i = 0; i < BLOCK_SIZE; i++) begin
            v = longint'(in_data[i]) >>> s;
            if (v < -(1 << (MANT_W - 1)) || v > (1 << (MANT_W - 1)) - 1)
              fits = 1'b0;
          end
          if (fits && !found) begin
            e     = s;
            found = 1'b1;
          end
        end
        for (int i = 0; i < BLOCK_SIZE; i++)
          m[i] = longint'(in_data[i]) >>> e;
        if (grp_n == 0) begin
          acc_exp = e;
          for (int i = 0; i < BLOCK_SIZE; i++)
            acc[i] = m[i];
        end else begin
          t = (e < acc_exp) ? e : acc_exp;
          for (int i = 0; i < BLOCK_SIZE; i++)
            acc[i] = (acc[i] <<< (acc_exp - t)) + (m[i] <<< (e - t));
          acc_exp = t;
        end
        grp_n++;
        blocks_in++;
        if (grp_n == IN_DEPTH) begin
          exp_q.push_back(acc_exp);
          for (int i = 0; i < BLOCK_SIZE; i++)
            mant_q.push_back(acc[i]);
          grp_n = 0;
          results_expected++;
        end
      end
    end
    head_valid <= (exp_q.size() != 0);
    if (exp_q.size() != 0) begin
      head_exp <= exp_q[0];
      for (int i = 0; i < BLOCK_SIZE; i++)
        head_mant[i] <= mant_q[i];
    end
  end

  always_comb begin
    mant_match = 1'b1;
    mant_zero  = 1'b1;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      if (longint'(out_mant[i]) != head_mant[i])
        mant_match = 1'b0;
      if (out_mant[i] != '0)
        mant_zero = 1'b0;
      out_flat[i*ACC_W +: ACC_W] = out_mant[i];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks.
  //////////////////////////////////////////////////////////////////////

  assert property (@(posedge clk) $fell(rst) |->
      !out_valid && in_ready && int'(out_exp) == EXP_MAX && mant_zero)
    else abort_run($sformatf("Fail %0t: outputs not at their reset values", $time));

  assert property (@(posedge clk) disable iff (rst)
      out_valid |-> head_valid && int'(out_exp) == head_exp && mant_match)
    else abort_run($sformatf("Fail %0t: result differs from the model", $time));

  // Held result must not move.
  assert property (@(posedge clk) disable iff (rst)
      $past(out_valid && !out_ready) |-> out_valid && $stable(out_exp) && $stable(out_flat))
    else abort_run($sformatf("Fail %0t: result changed under back-pressure", $time));

  initial begin
    int filled;
    int pad;
    lfsr      = 16'd57;
    rst       = 1'b1;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    for (int i = 0; i < BLOCK_SIZE; i++)
      in_data[i] = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (2) @(posedge clk);

    drive_blocks(12, 0, 1'b0, 1'b0);
    drive_blocks(12, 1, 1'b0, 1'b0);
    drive_blocks(30, 2, 1'b1, 1'b1);

    fill_until_blocked(filled);
    repeat (5) @(posedge clk);
    // Pending block plus enough to close the last sum.
    pad = (IN_DEPTH - (filled + 1) % IN_DEPTH) % IN_DEPTH;
    drive_blocks(1 + pad, 1, 1'b0, 1'b0);
    wait_drain();

    if (exp_q.size() == 0 && results_seen == results_expected
        && blocks_in % IN_DEPTH == 0 && results_seen == blocks_in / IN_DEPTH) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      abort_run($sformatf("Fail %0t: %0d results seen, %0d expected, %0d left queued",
                          $time, results_seen, results_expected, exp_q.size()));
    end
  end

endmodule

// ==== verilog/mxint_accum_top.sv ====
module mxint_accum_top #(
  parameter int BLOCK_SIZE   = mxint_format_pkg::BLOCK_SIZE_DEF,
  parameter int RAW_W        = mxint_format_pkg::RAW_W,
  parameter int MANT_W       = mxint_format_pkg::MANT_W,
  parameter int EXP_W        = mxint_format_pkg::EXP_W,
  parameter int FIFO_DEPTH   = mxint_flow_pkg::FIFO_DEPTH_DEF,
  parameter int IN_DEPTH     = mxint_flow_pkg::IN_DEPTH_DEF,
  localparam int ACC_W       = mxint_flow_pkg::acc_width(MANT_W, EXP_W, IN_DEPTH)
) (
  input  logic                    clk,
  input  logic                    rst,

  input  logic signed [RAW_W-1:0] in_data [BLOCK_SIZE],
  input  logic                    in_valid,
  output logic                    in_ready,

  output logic signed [ACC_W-1:0] out_mant [BLOCK_SIZE],
  output logic signed [EXP_W-1:0] out_exp,
  output logic                    out_valid,
  input  logic                    out_ready
);

  // Quantizer to FIFO.
  logic signed [MANT_W-1:0] q_mant [BLOCK_SIZE];
  logic signed [EXP_W-1:0]  q_exp;
  logic                     q_valid;
  logic                     q_ready;

  // FIFO to accumulator.
  logic signed [MANT_W-1:0] f_mant [BLOCK_SIZE];
  logic signed [EXP_W-1:0]  f_exp;
  logic                     f_valid;
  logic                     f_ready;

  mxint_block_quantizer #(
    .BLOCK_SIZE (BLOCK_SIZE),
    .RAW_W      (RAW_W),
    .MANT_W     (MANT_W),
    .EXP_W      (EXP_W)
  ) u_quantizer (
    .clk       (clk),
    .rst       (rst),
    .raw_data  (in_data),
    .raw_valid (in_valid),
    .raw_ready (in_ready),
    .q_mant    (q_mant),
    .q_exp     (q_exp),
    .q_valid   (q_valid),
    .q_ready   (q_ready)
  );

  mxint_block_fifo #(
    .BLOCK_SIZE (BLOCK_SIZE),
    .MANT_W     (MANT_W),
    .EXP_W      (EXP_W),
    .DEPTH      (FIFO_DEPTH)
  ) u_fifo (
    .clk      (clk),
    .rst      (rst),
    .wr_mant  (q_mant),
    .wr_exp   (q_exp),
    .wr_valid (q_valid),
    .wr_ready (q_ready),
    .rd_mant  (f_mant),
    .rd_exp   (f_exp),
    .rd_valid (f_valid),
    .rd_ready (f_ready)
  );

  mxint_accumulator #(
    .BLOCK_SIZE (BLOCK_SIZE),
    .MANT_W     (MANT_W),
    .EXP_W      (EXP_W),
    .IN_DEPTH   (IN_DEPTH),
    .ACC_W      (ACC_W)
  ) u_accumulator (
    .clk       (clk),
    .rst       (rst),
    .in_mant   (f_mant),
    .in_exp    (f_exp),
    .in_valid  (f_valid),
    .in_ready  (f_ready),
    .out_mant  (out_mant),
    .out_exp   (out_exp),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// ==== verilog/mxint_accumulator.sv ====
module mxint_accumulator #(
  parameter int BLOCK_SIZE = mxint_format_pkg::BLOCK_SIZE_DEF,
  parameter int MANT_W     = mxint_format_pkg::MANT_W,
  parameter int EXP_W      = mxint_format_pkg::EXP_W,
  parameter int IN_DEPTH   = mxint_flow_pkg::IN_DEPTH_DEF,
  parameter int ACC_W      = mxint_flow_pkg::acc_width(MANT_W, EXP_W, IN_DEPTH)
) (
  input  logic                     clk,
  input  logic                     rst,

  input  logic signed [MANT_W-1:0] in_mant [BLOCK_SIZE],
  input  logic signed [EXP_W-1:0]  in_exp,
  input  logic                     in_valid,
  output logic                     in_ready,

  output logic signed [ACC_W-1:0]  out_mant [BLOCK_SIZE],
  output logic signed [EXP_W-1:0]  out_exp,
  output logic                     out_valid,
  input  logic                     out_ready
);

  import mxint_format_pkg::*;

  localparam int CNT_W = $clog2(IN_DEPTH + 1);
  localparam logic signed [EXP_W-1:0] EXP_EMPTY = EXP_W'(exp_max_for(EXP_W));

  logic [CNT_W-1:0]        count;
  logic                    take;
  logic                    restart;
  logic                    first;
  logic signed [EXP_W-1:0] exp_tgt;
  logic [EXP_W-1:0]        in_sh;
  logic [EXP_W-1:0]        acc_sh;
  logic signed [ACC_W-1:0] in_ext [BLOCK_SIZE];
  logic signed [ACC_W-1:0] sum    [BLOCK_SIZE];

  assign out_valid = (count == CNT_W'(IN_DEPTH));
  assign in_ready  = !out_valid || out_ready;
  assign take      = in_valid && in_ready;
  assign restart   = out_valid && out_ready;
  // Block opens a new sum, either from empty or as the result leaves.
  assign first     = (count == '0) || restart;

  //////////////////////////////////////////////////////////////////////
  // Exponent alignment.
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (first || (in_exp < out_exp)) begin
      exp_tgt = in_exp;
    end else begin
      exp_tgt = out_exp;
    end
  end

  // Both operands move up to the common, smaller exponent.
  assign in_sh  = in_exp - exp_tgt;
  assign acc_sh = out_exp - exp_tgt;

  always_comb begin
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      in_ext[i] = ACC_W'(in_mant[i]) <<< in_sh;
      if (first) begin
        sum[i] = in_ext[i];
      end else begin
        sum[i] = (out_mant[i] <<< acc_sh) + in_ext[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Running state.
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst || (restart && !in_valid)) begin
      count   <= '0;
      out_exp <= EXP_EMPTY;
      for (int i = 0; i < BLOCK_SIZE; i++) begin
        out_mant[i] <= '0;
      end
    end else if (take) begin
      count   <= first ? CNT_W'(1) : count + 1'b1;
      out_exp <= exp_tgt;
      for (int i = 0; i < BLOCK_SIZE; i++) begin
        out_mant[i] <= sum[i];
      end
    end
  end

endmodule

// ==== verilog/mxint_block_fifo.sv ====
module mxint_block_fifo #(
  parameter int BLOCK_SIZE = mxint_format_pkg::BLOCK_SIZE_DEF,
  parameter int MANT_W     = mxint_format_pkg::MANT_W,
  parameter int EXP_W      = mxint_format_pkg::EXP_W,
  parameter int DEPTH      = mxint_flow_pkg::FIFO_DEPTH_DEF
) (
  input  logic                     clk,
  input  logic                     rst,

  input  logic signed [MANT_W-1:0] wr_mant [BLOCK_SIZE],
  input  logic signed [EXP_W-1:0]  wr_exp,
  input  logic                     wr_valid,
  output logic                     wr_ready,

  output logic signed [MANT_W-1:0] rd_mant [BLOCK_SIZE],
  output logic signed [EXP_W-1:0]  rd_exp,
  output logic                     rd_valid,
  input  logic                     rd_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage, one exponent and one mantissa row per entry.
  logic signed [MANT_W-1:0] mant_mem [DEPTH][BLOCK_SIZE];
  logic signed [EXP_W-1:0]  exp_mem  [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  // Wrap at DEPTH, which need not be a power of two.
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full     = (count == CNT_W'(DEPTH));
  assign rd_valid = (count != '0);
  // A full FIFO still takes a word when the head leaves on the same edge.
  assign wr_ready = !full || rd_ready;
  assign wr_en    = wr_valid && wr_ready;
  assign rd_en    = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (wr_en) begin
      exp_mem[wr_ptr] <= wr_exp;
      for (int i = 0; i < BLOCK_SIZE; i++) begin
        mant_mem[wr_ptr][i] <= wr_mant[i];
      end
    end
  end

  // Head word shown without a register.
  assign rd_exp = exp_mem[rd_ptr];
  for (genvar i = 0; i < BLOCK_SIZE; i++) begin : g_rd_lane
    assign rd_mant[i] = mant_mem[rd_ptr][i];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (rd_en) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// ==== verilog/mxint_block_quantizer.sv ====
module mxint_block_quantizer #(
  parameter int BLOCK_SIZE = mxint_format_pkg::BLOCK_SIZE_DEF,
  parameter int RAW_W      = mxint_format_pkg::RAW_W,
  parameter int MANT_W     = mxint_format_pkg::MANT_W,
  parameter int EXP_W      = mxint_format_pkg::EXP_W
) (
  input  logic                     clk,
  input  logic                     rst,

  input  logic signed [RAW_W-1:0]  raw_data [BLOCK_SIZE],
  input  logic                     raw_valid,
  output logic                     raw_ready,

  output logic signed [MANT_W-1:0] q_mant [BLOCK_SIZE],
  output logic signed [EXP_W-1:0]  q_exp,
  output logic                     q_valid,
  input  logic                     q_ready
);

  // Largest shift that can ever be needed.
  localparam int SHIFT_MAX = RAW_W - MANT_W;

  logic signed [EXP_W-1:0]  exp_sel;
  logic                     block_ok [SHIFT_MAX+1];
  logic signed [MANT_W-1:0] mant_next [BLOCK_SIZE];
  logic                     take;

  // True when v >>> e lies in the signed mantissa range.
  function automatic logic lane_fits(input logic signed [RAW_W-1:0] v, input int e);
    logic signed [RAW_W-1:0] s;
    s = v >>> e;
    return (s >= -(2 ** (MANT_W - 1))) && (s <= 2 ** (MANT_W - 1) - 1);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Shared exponent search.
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int e = 0; e <= SHIFT_MAX; e++) begin
      block_ok[e] = 1'b1;
      for (int i = 0; i < BLOCK_SIZE; i++) begin
        if (!lane_fits(raw_data[i], e)) begin
          block_ok[e] = 1'b0;
        end
      end
    end
  end

  // Smallest fitting shift wins, so scan downwards.
  always_comb begin
    exp_sel = EXP_W'(SHIFT_MAX);
    for (int e = SHIFT_MAX; e >= 0; e--) begin
      if (block_ok[e]) begin
        exp_sel = EXP_W'(e);
      end
    end
  end

  // Truncating arithmetic shift into the mantissa width.
  always_comb begin
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      mant_next[i] = MANT_W'(raw_data[i] >>> exp_sel);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output stage.
  //////////////////////////////////////////////////////////////////////

  assign raw_ready = !q_valid || q_ready;
  assign take      = raw_valid && raw_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      q_valid <= 1'b0;
    end else if (raw_ready) begin
      q_valid <= raw_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      q_exp <= exp_sel;
      for (int i = 0; i < BLOCK_SIZE; i++) begin
        q_mant[i] <= mant_next[i];
      end
    end
  end

endmodule

// ==== verilog/mxint_flow_pkg.sv ====
package mxint_flow_pkg;

  //////////////////////////////////////////////////////////////////////
  // Stream structure of the accumulation path.
  //////////////////////////////////////////////////////////////////////

  // Blocks buffered between quantizer and accumulator.
  localparam int FIFO_DEPTH_DEF = 4;

  // Blocks summed into one result.
  localparam int IN_DEPTH_DEF = 3;

  // Accumulator mantissa width, room for full left alignment plus growth.
  function automatic int acc_width(input int mant_w, input int exp_w, input int in_depth);
    return mant_w + 2 ** exp_w + $clog2(in_depth);
  endfunction

endpackage

// ==== verilog/mxint_format_pkg.sv ====
package mxint_format_pkg;

  //////////////////////////////////////////////////////////////////////
  // Number format of the MXINT path.
  //////////////////////////////////////////////////////////////////////

  // Raw input integer width.
  localparam int RAW_W = 14;

  // Quantized mantissa width.
  localparam int MANT_W = 8;

  // Signed shared exponent width.
  localparam int EXP_W = 4;

  // Lanes per block.
  localparam int BLOCK_SIZE_DEF = 4;

  // Largest positive value of a signed exponent field.
  function automatic int exp_max_for(input int exp_w);
    return 2 ** (exp_w - 1) - 1;
  endfunction

  // Value an empty accumulator reports as its exponent.
  localparam int EXP_MAX = exp_max_for(EXP_W);

endpackage

// ==== vlog.f ====
verilog/mxint_format_pkg.sv
verilog/mxint_flow_pkg.sv
verilog/mxint_block_quantizer.sv
verilog/mxint_block_fifo.sv
verilog/mxint_accumulator.sv
verilog/mxint_accum_top.sv
verif/tb_mxint_accum_top.sv
